// ==== design/daq_consts.svh ====
`ifndef DAQ_CONSTS_SVH
`define DAQ_CONSTS_SVH

//////////////////////////////
// Wake-up and settling times, in Clk cycles
//////////////////////////////

// ASIC reset hold after power-on, LVDS receiver wake-up
`define DAQ_POWER_RESET_CYCLES 8
// Settling before the first acquisition
`define DAQ_RESET_START_CYCLES 40
`define DAQ_SRO_CYCLES         16   // Extra start-readout length
`define DAQ_DATA_END_CYCLES    1600 // Drain wait for late data

//////////////////////////////
// Trailer words
//////////////////////////////

`define DAQ_TAIL_HEAD 16'hFF45
`define DAQ_COUNT_TAG 8'hCC  // Upper byte of the second word
`define DAQ_TAIL_END  16'h45FF

`endif

// ==== design/DaqPkg.sv ====
`default_nettype none

package DaqPkg;

    typedef logic [15:0] DaqWord_t;    // Data stream word
    typedef logic [23:0] TrigCount_t;  // Trigger count
    typedef logic [15:0] Delay_t;      // Cycle count for the delay timer

    // Run sequencer states
    typedef enum logic [3:0] {
        Idle,
        ChipReset,
        PowerOn,
        Release,
        WaitStart,
        Acquire,
        WaitRead,
        StartRo,
        WaitReadDone,
        OnceEndHold,
        WaitDataEnd,
        AllDoneWait
    } SeqState_t;

    // Pass forwards ASIC data, Word and Gap build the trailer
    typedef enum logic [1:0] {Pass, Word, Gap} TrailerState_t;

endpackage

`default_nettype wire

// ==== design/AsicEventIf.sv ====
`default_nettype none

// Synchronized ASIC events, all in the Clk domain
interface AsicEventIf;

    logic TrigEdge;   // Rising edge of AcqTrigger
    logic ChipFull;   // Falling edge of ChipSatB
    logic ReadStart;  // Rising edge of ChipSatB
    logic EndRead;    // Level of EndReadout

    modport Sync (
        output TrigEdge, ChipFull, ReadStart, EndRead
    );

    modport Seq (
        input TrigEdge, ChipFull, ReadStart, EndRead
    );

    // Only triggers are counted
    modport Count (
        input TrigEdge
    );

endinterface

`default_nettype wire

// ==== design/EdgeSync.sv ====
`default_nettype none

module EdgeSync (
    input  logic     Clk,
    input  logic     reset_n,
    input  logic     AcqTrigger,
    input  logic     ChipSatB,
    input  logic     EndReadout,
    AsicEventIf.Sync Events
);

    // Bit 0 trigger, bit 1 chip saturation, bit 2 end of readout
    localparam logic [2:0] PinIdle = 3'b010;  // ChipSatB is active low

    logic [2:0] Pins;
    logic [2:0] Stage1;   // Metastable stage
    logic [2:0] Stage2;   // Synchronized level
    logic [2:0] Stage3;   // Previous level, for edge detection

    assign Pins = {EndReadout, ChipSatB, AcqTrigger};

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            Stage1 <= PinIdle;
            Stage2 <= PinIdle;
            Stage3 <= PinIdle;
        end else begin
            Stage1 <= Pins;
            Stage2 <= Stage1;
            Stage3 <= Stage2;
        end
    end

    //////////////////////////////
    // Registered event strobes
    //////////////////////////////
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            Events.TrigEdge  <= 1'b0;
            Events.ChipFull  <= 1'b0;
            Events.ReadStart <= 1'b0;
            Events.EndRead   <= 1'b0;
        end else begin
            Events.TrigEdge  <= Stage2[0] & ~Stage3[0];
            Events.ChipFull  <= ~Stage2[1] & Stage3[1];   // One or more chips full
            Events.ReadStart <= Stage2[1] & ~Stage3[1];   // Readout may start
            Events.EndRead   <= Stage2[2];
        end
    end

endmodule

`default_nettype wire

// ==== design/TrigCounter.sv ====
`default_nettype none

module TrigCounter (
    input  logic               Clk,
    input  logic               reset_n,
    AsicEventIf.Count          Events,
    input  logic               CountClear,
    input  logic               CountEnable,
    output DaqPkg::TrigCount_t TrigCount
);

    // Counts every trigger while the run is open,
    // also the ones that land inside an acquisition window
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            TrigCount <= '0;
        end else if (CountClear) begin
            TrigCount <= '0;                   // New run
        end else if (CountEnable && Events.TrigEdge) begin
            TrigCount <= TrigCount + 1'b1;     // Wraps at 24 bits
        end
    end

endmodule

`default_nettype wire

// ==== design/AcqSequencer.sv ====
`default_nettype none

`include "daq_consts.svh"

module AcqSequencer (
    input  logic           Clk,
    input  logic           reset_n,
    input  logic           ModuleStart,
    input  DaqPkg::Delay_t AcquisitionTime,
    input  DaqPkg::Delay_t EndHoldTime,
    AsicEventIf.Seq        Events,
    input  logic           DataTransmitDone,
    input  logic           TrailerDone,
    output logic           ResetB,
    output logic           StartAcq,
    output logic           ForceExternalRaz,
    output logic           StartReadout,
    output logic           PwrOnA,
    output logic           PwrOnD,
    output logic           PwrOnDac,
    output logic           OnceEnd,
    output logic           AllDone,
    output logic           CountClear,
    output logic           CountEnable,
    output logic           TrailerGo
);

    import DaqPkg::*;

    SeqState_t  State;
    Delay_t     Delay;        // Shared delay timer
    logic [11:0] DrainCount;  // Late data drain before the trailer
    logic       DoneHeld;     // Trailer sent, waiting for the host
    logic       AnaPower;

    //////////////////////////////
    // Run state machine
    //////////////////////////////
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            State        <= Idle;
            Delay        <= '0;
            DrainCount   <= '0;
            ResetB       <= 1'b1;
            StartAcq     <= 1'b0;
            StartReadout <= 1'b0;
            OnceEnd      <= 1'b0;
            CountClear   <= 1'b0;
            CountEnable  <= 1'b0;
            TrailerGo    <= 1'b0;
            DoneHeld     <= 1'b0;
        end else begin
            CountClear <= 1'b0;
            TrailerGo  <= 1'b0;
            case (State)
                Idle: begin
                    if (ModuleStart) begin
                        ResetB     <= 1'b0;   // Hold the ASIC digital part in reset
                        CountClear <= 1'b1;
                        State      <= ChipReset;
                    end
                end
                ChipReset: begin
                    State <= PowerOn;
                end
                PowerOn: begin
                    if (Delay < Delay_t'(`DAQ_POWER_RESET_CYCLES)) begin
                        Delay <= Delay + 1'b1;
                    end else begin
                        Delay  <= '0;
                        ResetB <= 1'b1;
                        State  <= Release;
                    end
                end
                Release: begin
                    if (Delay < Delay_t'(`DAQ_RESET_START_CYCLES)) begin
                        Delay <= Delay + 1'b1;
                    end else begin
                        Delay       <= '0;
                        CountEnable <= 1'b1;  // Startup complete
                        State       <= WaitStart;
                    end
                end
                WaitStart: begin
                    if (!ModuleStart) begin
                        CountEnable <= 1'b0;
                        DrainCount  <= '0;
                        State       <= WaitDataEnd;
                    end else if (Events.TrigEdge) begin
                        StartAcq <= 1'b1;
                        State    <= Acquire;
                    end
                end
                Acquire: begin
                    // Window closes on timeout or when a chip is full
                    if (Delay >= AcquisitionTime || Events.ChipFull) begin
                        Delay    <= '0;
                        StartAcq <= 1'b0;
                        State    <= WaitRead;
                    end else begin
                        Delay <= Delay + 1'b1;
                    end
                end
                WaitRead: begin
                    if (Events.ReadStart) begin
                        StartReadout <= 1'b1;
                        State        <= StartRo;
                    end
                end
                StartRo: begin
                    if (Delay < Delay_t'(`DAQ_SRO_CYCLES)) begin
                        Delay <= Delay + 1'b1;
                    end else begin
                        Delay        <= '0;
                        StartReadout <= 1'b0;
                        State        <= WaitReadDone;
                    end
                end
                WaitReadDone: begin
                    if (Events.EndRead) begin
                        OnceEnd <= 1'b1;
                        State   <= OnceEndHold;
                    end
                end
                OnceEndHold: begin
                    if (Delay < EndHoldTime) begin
                        Delay <= Delay + 1'b1;
                    end else begin
                        Delay   <= '0;
                        OnceEnd <= 1'b0;
                        State   <= WaitStart;  // Ready for the next trigger
                    end
                end
                WaitDataEnd: begin
                    if (DrainCount < 12'(`DAQ_DATA_END_CYCLES)) begin
                        DrainCount <= DrainCount + 1'b1;
                    end else begin
                        DrainCount <= '0;
                        TrailerGo  <= 1'b1;
                        State      <= AllDoneWait;
                    end
                end
                AllDoneWait: begin
                    if (AllDone && DataTransmitDone) begin
                        DoneHeld <= 1'b0;
                        State    <= Idle;
                    end else if (TrailerDone) begin
                        DoneHeld <= 1'b1;
                    end
                end
                default: begin
                    State <= Idle;
                end
            endcase
        end
    end

    // Raz is forced whenever no window is open
    assign ForceExternalRaz = ~StartAcq;

    // Rises on the trailer strobe itself, then holds until the host is done
    assign AllDone = TrailerDone | DoneHeld;

    //////////////////////////////
    // Power pulsing
    //////////////////////////////
    assign AnaPower = State inside {ChipReset, PowerOn, Release, WaitStart, Acquire,
                                    WaitRead, StartRo, WaitReadDone, OnceEndHold};

    assign PwrOnA   = AnaPower;
    assign PwrOnDac = AnaPower;
    assign PwrOnD   = AnaPower && (State != ChipReset);  // Digital part one cycle later

endmodule

`default_nettype wire

// ==== design/TrailerMux.sv ====
`default_nettype none

`include "daq_consts.svh"

module TrailerMux (
    input  logic               Clk,
    input  logic               reset_n,
    input  logic               TrailerGo,
    input  DaqPkg::TrigCount_t TrigCount,
    input  DaqPkg::DaqWord_t   MicrorocData,
    input  logic               MicrorocDataEn,
    output DaqPkg::DaqWord_t   SlaveDaqData,
    output logic               SlaveDaqDataEn,
    output logic               TrailerDone
);

    import DaqPkg::*;

    TrailerState_t State;
    logic [1:0]    WordIdx;      // Trailer word being sent
    TrigCount_t    CountHold;    // Count frozen at the start of the trailer
    DaqWord_t      TrailerWord;

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            State       <= Pass;
            WordIdx     <= '0;
            TrailerDone <= 1'b0;
        end else begin
            TrailerDone <= 1'b0;
            case (State)
                Pass: begin
                    if (TrailerGo) begin
                        WordIdx <= '0;
                        State   <= Word;
                    end
                end
                Word: State <= Gap;     // One enabled cycle per word
                Gap: begin
                    if (WordIdx == 2'd3) begin
                        TrailerDone <= 1'b1;
                        State       <= Pass;
                    end else begin
                        WordIdx <= WordIdx + 1'b1;
                        State   <= Word;
                    end
                end
                default: State <= Pass;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (State == Pass && TrailerGo)
            CountHold <= TrigCount;
    end

    always_comb begin
        case (WordIdx)
            2'd0:    TrailerWord = `DAQ_TAIL_HEAD;
            2'd1:    TrailerWord = {`DAQ_COUNT_TAG, CountHold[23:16]};
            2'd2:    TrailerWord = CountHold[15:0];
            default: TrailerWord = `DAQ_TAIL_END;
        endcase
    end

    // ASIC words arriving during the trailer are dropped
    assign SlaveDaqData   = (State == Pass) ? MicrorocData : TrailerWord;
    assign SlaveDaqDataEn = (State == Pass) ? MicrorocDataEn : (State == Word);

endmodule

`default_nettype wire

// ==== design/SlaveDaq.sv ====
`default_nettype none

module SlaveDaq (
    input  logic             Clk,
    input  logic             reset_n,
    input  logic             ModuleStart,       // Run enable from the host
    input  logic             AcqTrigger,        // External trigger, asynchronous
    input  logic             ChipSatB,          // Chip full, active low
    input  logic             EndReadout,        // Digital RAM readout finished
    input  DaqPkg::Delay_t   AcquisitionTime,
    input  DaqPkg::Delay_t   EndHoldTime,
    input  DaqPkg::DaqWord_t MicrorocData,
    input  logic             MicrorocDataEn,
    input  logic             DataTransmitDone,
    output logic             ResetB,
    output logic             StartAcq,
    output logic             ForceExternalRaz,
    output logic             StartReadout,
    output logic             PwrOnA,
    output logic             PwrOnD,
    output logic             PwrOnDac,
    output logic             OnceEnd,
    output logic             AllDone,
    output DaqPkg::DaqWord_t SlaveDaqData,
    output logic             SlaveDaqDataEn
);

    import DaqPkg::*;

    logic       CountClear;
    logic       CountEnable;
    TrigCount_t TrigCount;
    logic       TrailerGo;
    logic       TrailerDone;

    AsicEventIf Events ();

    //////////////////////////////
    // Blocks
    //////////////////////////////
    EdgeSync edgeSync0 (
        .Clk        (Clk),
        .reset_n    (reset_n),
        .AcqTrigger (AcqTrigger),
        .ChipSatB   (ChipSatB),
        .EndReadout (EndReadout),
        .Events     (Events.Sync)
    );

    TrigCounter trigCounter0 (
        .Clk         (Clk),
        .reset_n     (reset_n),
        .Events      (Events.Count),
        .CountClear  (CountClear),
        .CountEnable (CountEnable),
        .TrigCount   (TrigCount)
    );

    AcqSequencer acqSequencer0 (
        .Clk              (Clk),
        .reset_n          (reset_n),
        .ModuleStart      (ModuleStart),
        .AcquisitionTime  (AcquisitionTime),
        .EndHoldTime      (EndHoldTime),
        .Events           (Events.Seq),
        .DataTransmitDone (DataTransmitDone),
        .TrailerDone      (TrailerDone),
        .ResetB           (ResetB),
        .StartAcq         (StartAcq),
        .ForceExternalRaz (ForceExternalRaz),
        .StartReadout     (StartReadout),
        .PwrOnA           (PwrOnA),
        .PwrOnD           (PwrOnD),
        .PwrOnDac         (PwrOnDac),
        .OnceEnd          (OnceEnd),
        .AllDone          (AllDone),
        .CountClear       (CountClear),
        .CountEnable      (CountEnable),
        .TrailerGo        (TrailerGo)
    );

    TrailerMux trailerMux0 (
        .Clk            (Clk),
        .reset_n        (reset_n),
        .TrailerGo      (TrailerGo),
        .TrigCount      (TrigCount),
        .MicrorocData   (MicrorocData),
        .MicrorocDataEn (MicrorocDataEn),
        .SlaveDaqData   (SlaveDaqData),
        .SlaveDaqDataEn (SlaveDaqDataEn),
        .TrailerDone    (TrailerDone)
    );

endmodule

`default_nettype wire

// ==== tb/SlaveDaqModel.sv ====
`default_nettype none

`include "daq_consts.svh"

module SlaveDaqModel (
    input  logic             Clk,
    input  logic             reset_n,
    input  logic             AcqTrigger,
    input  logic             Counting,        // Between startup and the fall of ModuleStart
    input  logic             StopPhase,       // Drain and trailer phase of a run
    input  DaqPkg::DaqWord_t MicrorocData,
    input  logic             MicrorocDataEn,
    input  DaqPkg::DaqWord_t SlaveDaqData,
    input  logic             SlaveDaqDataEn,
    output logic             CheckValid,
    output logic [16:0]      Got,
    output logic [16:0]      Exp,
    output logic [2:0]       WordsSeen
);

    timeunit 1ns;
    timeprecision 1ps;

    import DaqPkg::*;

    TrigCount_t Count = '0;
    logic       TrigLast = 1'b0;

    // Expected trailer word, built from the trigger count
    function automatic DaqWord_t trailerWord(input logic [2:0] idx, input TrigCount_t cnt);
        case (idx)
            3'd0:    return `DAQ_TAIL_HEAD;
            3'd1:    return {`DAQ_COUNT_TAG, cnt[23:16]};
            3'd2:    return cnt[15:0];
            default: return `DAQ_TAIL_END;
        endcase
    endfunction

    //////////////////////////////
    // Trigger count and trailer position
    //////////////////////////////
    always @(negedge Clk) begin
        TrigLast <= AcqTrigger;
        if (!reset_n) begin
            Count <= '0;
        end else if (Counting && AcqTrigger && !TrigLast) begin
            Count <= Count + 24'd1;
        end else if (!Counting && !StopPhase) begin
            Count <= '0;  // Between runs
        end
        if (!StopPhase)
            WordsSeen <= '0;
        else if (SlaveDaqDataEn && WordsSeen != 3'd7)
            WordsSeen <= WordsSeen + 3'd1;
    end

    // Stream checker outputs, read by the testbench at the falling edge
    always_comb begin
        if (!StopPhase) begin
            CheckValid = 1'b1;   // Straight passthrough of word and enable
            Got        = {SlaveDaqDataEn, SlaveDaqData};
            Exp        = {MicrorocDataEn, MicrorocData};
        end else begin
            CheckValid = SlaveDaqDataEn;
            Got        = {1'b1, SlaveDaqData};
            // A fifth word never matches
            Exp        = (WordsSeen < 3'd4) ? {1'b1, trailerWord(WordsSeen, Count)} : 17'h0;
        end
    end

endmodule

`default_nettype wire

// ==== tb/SlaveDaqTb.sv ====
`default_nettype none

`include "daq_consts.svh"

module SlaveDaqTb;

    timeunit 1ns;
    timeprecision 1ps;

    import DaqPkg::*;

    logic     Clk;
    logic     reset_n;
    logic     ModuleStart, AcqTrigger, ChipSatB, EndReadout, DataTransmitDone;
    Delay_t   AcquisitionTime, EndHoldTime;
    DaqWord_t MicrorocData;
    logic     MicrorocDataEn;
    logic     ResetB, StartAcq, ForceExternalRaz, StartReadout;
    logic     PwrOnA, PwrOnD, PwrOnDac, OnceEnd, AllDone;
    DaqWord_t SlaveDaqData;
    logic     SlaveDaqDataEn;

    logic        Counting, StopPhase, DataOn;
    logic        CheckValid;
    logic [16:0] Got, Exp;
    logic [2:0]  WordsSeen;

    SlaveDaq dut0 (.*);

    SlaveDaqModel model0 (.*);

    task automatic compareValues(input logic [31:0] got, input logic [31:0] exp,
                                 input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic reportTimeout(input string what);
        $display("Timed out at %0t ns waiting for %s", $time, what);
        $display("RESULT: FAIL");
        $fatal(1, "Timeout");
    endtask

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    // Random ASIC words, also the stimulus for the passthrough check
    initial begin
        MicrorocData   = '0;
        MicrorocDataEn = 1'b0;
        forever begin
            @(posedge Clk);
            MicrorocData   <= DaqWord_t'($urandom);
            MicrorocDataEn <= DataOn ? 1'($urandom % 2) : 1'b0;
        end
    end

    always @(negedge Clk) begin
        if (reset_n && CheckValid)
            compareValues(32'(Got), 32'(Exp), "data stream word");
    end

    initial begin
        int  t, len, e, at, eh, nTrig;
        bit  early, extra;
        void'($urandom(29));
        reset_n = 1'b0;
        ModuleStart = 1'b0;
        AcqTrigger = 1'b0;
        ChipSatB = 1'b1;           // Active low, idle high
        EndReadout = 1'b0;
        DataTransmitDone = 1'b0;
        AcquisitionTime = '0;
        EndHoldTime = '0;
        Counting = 1'b0;
        StopPhase = 1'b0;
        DataOn = 1'b1;
        repeat (4) @(posedge Clk);
        reset_n <= 1'b1;
        @(negedge Clk);
        compareValues(32'({ResetB, ForceExternalRaz}), 32'h3, "ResetB and Raz after reset");
        compareValues(32'({StartAcq, StartReadout, PwrOnA, PwrOnD, PwrOnDac, OnceEnd, AllDone}),
                      0, "control outputs after reset");

        for (int run = 0; run < 5; run++) begin
            at = 5 + $urandom % 36;
            eh = $urandom % 11;
            nTrig = 1 + $urandom % 6;
            @(posedge Clk);
            AcquisitionTime <= 16'(at);
            EndHoldTime <= 16'(eh);
            ModuleStart <= 1'b1;
            t = 0;
            do begin
                @(negedge Clk);
                if (++t > 10) reportTimeout("ResetB to fall");
            end while (ResetB);

            //////////////////////////////
            // Startup
            //////////////////////////////
            len = 0;
            while (!ResetB) begin
                compareValues(32'({PwrOnA, PwrOnDac}), 32'h3, "analogue power in chip reset");
                compareValues(32'(PwrOnD), 32'(len > 0), "digital power in chip reset");
                if (++len > 20) reportTimeout("ResetB to rise");
                @(negedge Clk);
            end
            compareValues(len, `DAQ_POWER_RESET_CYCLES + 2, "ResetB low length");
            repeat (`DAQ_RESET_START_CYCLES + 4) @(negedge Clk);
            @(posedge Clk);
            Counting <= 1'b1;

            for (int k = 0; k < nTrig; k++) begin
                repeat (2 + $urandom % 8) @(posedge Clk);
                AcqTrigger <= 1'b1;
                repeat (2) @(posedge Clk);
                AcqTrigger <= 1'b0;
                t = 0;
                do begin
                    @(negedge Clk);
                    if (++t > 20) reportTimeout("StartAcq after trigger");
                end while (!StartAcq);
                early = 1'($urandom % 2);
                extra = 1'($urandom % 2);
                e = 1 + $urandom % (at - 4);
                len = 0;
                while (StartAcq) begin
                    compareValues(32'(ForceExternalRaz), 0, "Raz inside window");
                    if (++len > 60) reportTimeout("StartAcq to fall");
                    @(posedge Clk);
                    if (early && len == e) ChipSatB <= 1'b0;      // Chip full
                    if (extra && len == 1) AcqTrigger <= 1'b1;    // Trigger inside window
                    if (len == 3) AcqTrigger <= 1'b0;
                    @(negedge Clk);
                end
                compareValues(32'(ForceExternalRaz), 1, "Raz after window");
                if (early)
                    compareValues(32'(len <= at), 1, "window cut short by chip full");
                else
                    compareValues(len, at + 1, "StartAcq length");

                // Readout request from the ASIC
                @(posedge Clk);
                AcqTrigger <= 1'b0;
                ChipSatB <= 1'b0;
                repeat (4) @(posedge Clk);
                ChipSatB <= 1'b1;
                t = 0;
                do begin
                    @(negedge Clk);
                    if (++t > 20) reportTimeout("StartReadout");
                end while (!StartReadout);
                len = 0;
                while (StartReadout) begin
                    compareValues(32'({PwrOnA, PwrOnD, PwrOnDac}), 32'h7, "power in readout");
                    if (++len > 40) reportTimeout("StartReadout to fall");
                    @(negedge Clk);
                end
                compareValues(len, `DAQ_SRO_CYCLES + 1, "StartReadout length");
                @(posedge Clk);
                EndReadout <= 1'b1;
                t = 0;
                do begin
                    @(negedge Clk);
                    if (++t > 20) reportTimeout("OnceEnd");
                end while (!OnceEnd);
                len = 0;
                while (OnceEnd) begin
                    compareValues(32'({PwrOnA, PwrOnD, PwrOnDac}), 32'h7, "power in end hold");
                    if (++len > 30) reportTimeout("OnceEnd to fall");
                    @(posedge Clk);
                    EndReadout <= 1'b0;
                    @(negedge Clk);
                end
                compareValues(len, eh + 1, "OnceEnd length");
            end

            //////////////////////////////
            // Stop and trailer
            //////////////////////////////
            @(posedge Clk);
            DataOn <= 1'b0;   // Last ASIC word goes out before the stop phase
            @(posedge Clk);
            ModuleStart <= 1'b0;
            Counting <= 1'b0;
            StopPhase <= 1'b1;
            t = 0;
            do begin
                @(negedge Clk);
                if (++t > `DAQ_DATA_END_CYCLES + 60) reportTimeout("AllDone after stop");
            end while (!AllDone);
            compareValues(32'(WordsSeen), 4, "trailer word count");
            compareValues(32'({PwrOnA, PwrOnD, PwrOnDac}), 0, "power after stop");
            repeat (3) @(negedge Clk);
            compareValues(32'(AllDone), 1, "AllDone held");
            @(posedge Clk);
            DataTransmitDone <= 1'b1;
            @(posedge Clk);
            DataTransmitDone <= 1'b0;
            @(negedge Clk);
            compareValues(32'(AllDone), 0, "AllDone after DataTransmitDone");
            @(posedge Clk);
            StopPhase <= 1'b0;
            DataOn <= 1'b1;
        end
        repeat (4) @(posedge Clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+design
design/DaqPkg.sv
design/AsicEventIf.sv
design/EdgeSync.sv
design/TrigCounter.sv
design/AcqSequencer.sv
design/TrailerMux.sv
design/SlaveDaq.sv
tb/SlaveDaqModel.sv
tb/SlaveDaqTb.sv

// ==== Makefile ====
SIM  := obj_dir/VSlaveDaqTb
SRCS := $(shell grep -v '^+' all.f) design/daq_consts.svh

.PHONY: run clean

run: $(SIM)
	./$(SIM)

$(SIM): all.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module SlaveDaqTb -f all.f

clean:
	rm -rf obj_dir
